/* files.f */
+incdir+hw
hw/fp_noncomp_pkg.sv
hw/fp_pipe_stage.sv
hw/fp_classifier.sv
hw/fp_noncomp_ops.sv
hw/fp_noncomp.sv
verif/fp_noncomp_props.sv
verif/fp_noncomp_tb.sv

/* hw/fp_classifier.sv */
// Special-value decoder for the two binary32 operands
`timescale 1ns/100ps
`include "fp_noncomp_params.svh"

module fp_classifier (
  input  fp_noncomp_pkg::fp_word_t [1:0] operands_i,
  output fp_noncomp_pkg::fp_info_t [1:0] info_o
);

  import fp_noncomp_pkg::*;

  always_comb begin : classify_operands
    fp_num_t num;
    logic    exp_zero;
    logic    exp_ones;
    logic    man_zero;
    for (int i = 0; i < 2; i++) begin
      num      = operands_i[i];
      exp_zero = (num.exponent == '0);
      exp_ones = (num.exponent == '1);
      man_zero = (num.mantissa == '0);
      // Finite classes
      info_o[i].is_normal    = !exp_zero && !exp_ones;
      info_o[i].is_subnormal = exp_zero && !man_zero;
      info_o[i].is_zero      = exp_zero && man_zero;
      // Maximum exponent holds infinities and NaNs
      info_o[i].is_inf       = exp_ones && man_zero;
      info_o[i].is_nan       = exp_ones && !man_zero;
      // Quiet bit is the top fraction bit
      info_o[i].is_signalling = exp_ones && !man_zero && !num.mantissa[`FP_MAN_BITS-1];
      info_o[i].is_quiet      = exp_ones && num.mantissa[`FP_MAN_BITS-1];
    end
  end

endmodule

/* hw/fp_noncomp.sv */
// Top level of the binary32 non-computational unit with two register stages
`timescale 1ns/100ps

module fp_noncomp (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Request side
  input  fp_noncomp_pkg::fp_req_t  req_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  // Drops all items in flight
  input  logic                     flush_i,
  // Response side
  output fp_noncomp_pkg::fp_resp_t resp_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  // High while any stage holds an item
  output logic                     busy_o
);

  import fp_noncomp_pkg::*;

  fp_req_t             req_q;
  logic                in_stage_valid;
  logic                out_stage_ready;
  fp_info_t [1:0]      info;
  fp_resp_t            resp_d;

  // --------------------------------------------------
  // Input register stage
  // --------------------------------------------------
  fp_pipe_stage #(
    .payload_t (fp_req_t)
  ) u_in_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .data_i  (req_i),
    .ready_o (in_ready_o),
    .ready_i (out_stage_ready),
    .valid_o (in_stage_valid),
    .data_o  (req_q)
  );

  // --------------------------------------------------
  // Combinational operation path
  // --------------------------------------------------
  fp_classifier u_classifier (
    .operands_i (req_q.operands),
    .info_o     (info)
  );

  fp_noncomp_ops u_ops (
    .req_i    (req_q),
    .info_a_i (info[0]),
    .info_b_i (info[1]),
    .resp_o   (resp_d)
  );

  // --------------------------------------------------
  // Output register stage
  // --------------------------------------------------
  fp_pipe_stage #(
    .payload_t (fp_resp_t)
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_stage_valid),
    .data_i  (resp_d),
    .ready_o (out_stage_ready),
    .ready_i (out_ready_i),
    .valid_o (out_valid_o),
    .data_o  (resp_o)
  );

  assign busy_o = in_stage_valid | out_valid_o;

endmodule

/* hw/fp_noncomp_ops.sv */
// Sign injection, min/max, comparison, classification and result select
`timescale 1ns/100ps

module fp_noncomp_ops (
  input  fp_noncomp_pkg::fp_req_t  req_i,
  input  fp_noncomp_pkg::fp_info_t info_a_i,
  input  fp_noncomp_pkg::fp_info_t info_b_i,
  output fp_noncomp_pkg::fp_resp_t resp_o
);

  import fp_noncomp_pkg::*;

  fp_num_t operand_a;
  fp_num_t operand_b;
  logic    any_nan;
  logic    signalling_nan;
  logic    operands_equal;
  logic    operand_a_smaller;

  assign operand_a = req_i.operands[0];
  assign operand_b = req_i.operands[1];

  // Special cases shared by min/max and compare
  assign any_nan        = info_a_i.is_nan | info_b_i.is_nan;
  assign signalling_nan = info_a_i.is_signalling | info_b_i.is_signalling;

  // Both zeros compare equal whatever their sign
  assign operands_equal = (req_i.operands[0] == req_i.operands[1]) ||
                          (info_a_i.is_zero && info_b_i.is_zero);
  // Unsigned magnitude order, flipped once a sign bit is involved
  // so that -0 sorts below +0
  assign operand_a_smaller = (req_i.operands[0] < req_i.operands[1]) ^
                             (operand_a.sign || operand_b.sign);

  // --------------------------------------------------
  // Sign injection
  // --------------------------------------------------
  fp_num_t sgnj_result;

  always_comb begin : sign_injection
    sgnj_result = operand_a;
    unique case (req_i.rm)
      RM_RNE:  sgnj_result.sign = operand_b.sign;
      RM_RTZ:  sgnj_result.sign = ~operand_b.sign;
      RM_RDN:  sgnj_result.sign = operand_a.sign ^ operand_b.sign;
      // RUP and unused codes pass operand a through
      default: sgnj_result = operand_a;
    endcase
  end

  // --------------------------------------------------
  // Minimum and maximum
  // --------------------------------------------------
  fp_word_t   minmax_result;
  fp_status_t minmax_status;

  always_comb begin : min_max
    minmax_status    = '0;
    // Quiet compare, only a signalling NaN is invalid
    minmax_status.nv = signalling_nan;
    if (info_a_i.is_nan && info_b_i.is_nan) begin
      minmax_result = CANONICAL_QNAN;
    end else if (info_a_i.is_nan) begin
      minmax_result = operand_b;
    end else if (info_b_i.is_nan) begin
      minmax_result = operand_a;
    end else if (req_i.rm == RM_RTZ) begin
      // Max
      minmax_result = operand_a_smaller ? operand_b : operand_a;
    end else begin
      // Min
      minmax_result = operand_a_smaller ? operand_a : operand_b;
    end
  end

  // --------------------------------------------------
  // Comparison
  // --------------------------------------------------
  logic       cmp_bit;
  fp_status_t cmp_status;

  always_comb begin : compare
    cmp_bit    = 1'b0;
    cmp_status = '0;
    if (signalling_nan) begin
      // Invalid in every mode, false and never inverted
      cmp_status.nv = 1'b1;
    end else begin
      unique case (req_i.rm)
        RM_RNE: begin
          // LE is a signalling compare
          cmp_status.nv = any_nan;
          cmp_bit = (!any_nan && (operand_a_smaller || operands_equal)) ^ req_i.op_mod;
        end
        RM_RTZ: begin
          // LT is a signalling compare
          cmp_status.nv = any_nan;
          cmp_bit = (!any_nan && operand_a_smaller && !operands_equal) ^ req_i.op_mod;
        end
        RM_RDN: begin
          // EQ is quiet, a NaN is never equal
          cmp_bit = (!any_nan && operands_equal) ^ req_i.op_mod;
        end
        default: cmp_bit = 1'b0;
      endcase
    end
  end

  // --------------------------------------------------
  // Classification
  // --------------------------------------------------
  fp_classmask_e class_mask;

  // Always computed on operand a
  always_comb begin : classify
    if (info_a_i.is_normal) begin
      class_mask = operand_a.sign ? NEGNORM : POSNORM;
    end else if (info_a_i.is_subnormal) begin
      class_mask = operand_a.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_a_i.is_zero) begin
      class_mask = operand_a.sign ? NEGZERO : POSZERO;
    end else if (info_a_i.is_inf) begin
      class_mask = operand_a.sign ? NEGINF : POSINF;
    end else begin
      class_mask = info_a_i.is_signalling ? SNAN : QNAN;
    end
  end

  // --------------------------------------------------
  // Result select
  // --------------------------------------------------
  always_comb begin : select_result
    resp_o.status = '0;
    unique case (req_i.op)
      OP_SGNJ: begin
        // Sign injection never raises a flag
        resp_o.result = sgnj_result;
      end
      OP_MINMAX: begin
        resp_o.result = minmax_result;
        resp_o.status = minmax_status;
      end
      OP_CMP: begin
        // Boolean lands in bit 0
        resp_o.result = fp_word_t'(cmp_bit);
        resp_o.status = cmp_status;
      end
      default: begin
        // Classify reports on the mask port only
        resp_o.result = '0;
      end
    endcase
  end

  assign resp_o.class_mask = class_mask;
  assign resp_o.is_class   = (req_i.op == OP_CLASSIFY);
  assign resp_o.tag        = req_i.tag;

endmodule

/* hw/fp_noncomp_params.svh */
// Width defines for the binary32 format and the transaction tag
`ifndef FP_NONCOMP_PARAMS_SVH
`define FP_NONCOMP_PARAMS_SVH

// --------------------------------------------------
// Binary32 word layout
// --------------------------------------------------
// Full word width
`define FP_WIDTH 32
// Biased exponent field
`define FP_EXP_BITS 8
// Fraction field, hidden bit not stored
`define FP_MAN_BITS 23

// --------------------------------------------------
// Side-band
// --------------------------------------------------
// Tag travels with each item so the sender can match responses
`define FP_TAG_WIDTH 4

`endif

/* hw/fp_noncomp_pkg.sv */
// Word, field, flag, info, operation, rounding-field, class-mask and payload types
`include "fp_noncomp_params.svh"

package fp_noncomp_pkg;

  // Plain vectors with a meaning
  typedef logic [`FP_WIDTH-1:0]     fp_word_t;
  typedef logic [`FP_TAG_WIDTH-1:0] fp_tag_t;

  // Field view of a word
  typedef struct packed {
    logic                    sign;
    logic [`FP_EXP_BITS-1:0] exponent;
    logic [`FP_MAN_BITS-1:0] mantissa;
  } fp_num_t;

  // IEEE status flags, in the order of the RISC-V fflags field
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_status_t;

  // Special-value decode of one operand
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  typedef enum logic [1:0] {
    OP_SGNJ     = 2'd0,
    OP_MINMAX   = 2'd1,
    OP_CMP      = 2'd2,
    OP_CLASSIFY = 2'd3
  } fp_op_e;

  // Sub-operation is carried in the rounding-mode field
  typedef enum logic [2:0] {
    RM_RNE = 3'b000,
    RM_RTZ = 3'b001,
    RM_RDN = 3'b010,
    RM_RUP = 3'b011
  } fp_rm_e;

  // One-hot class mask, bit order as returned by FCLASS
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } fp_classmask_e;

  // Input stage payload, operand a at index 0
  typedef struct packed {
    fp_word_t [1:0] operands;
    fp_op_e         op;
    fp_rm_e         rm;
    logic           op_mod;
    fp_tag_t        tag;
  } fp_req_t;

  // Output stage payload
  typedef struct packed {
    fp_word_t      result;
    fp_status_t    status;
    fp_classmask_e class_mask;
    logic          is_class;
    fp_tag_t       tag;
  } fp_resp_t;

  // Positive quiet NaN with only the top fraction bit set
  localparam fp_word_t CANONICAL_QNAN = {1'b0, {`FP_EXP_BITS{1'b1}}, 1'b1,
                                         {(`FP_MAN_BITS-1){1'b0}}};

endpackage

/* hw/fp_pipe_stage.sv */
// One handshaked register stage with synchronous flush
`timescale 1ns/100ps

module fp_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  // Downstream side
  input  logic     ready_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  // Accept when empty or when the held item leaves this cycle
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // Drop whatever is held
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // --------------------------------------------------
  // Payload
  // --------------------------------------------------
  // Loads only on a real transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, exit status follows the simulation
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module fp_noncomp_tb -f files.f -o fp_noncomp_sim
./obj_dir/fp_noncomp_sim

/* verif/fp_noncomp_props.sv */
// Bound assertions on handshake, busy, reset and flush of the top level
`timescale 1ns/100ps

module fp_noncomp_props (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     flush_i,
  input logic                     in_valid_i,
  input logic                     in_ready_i,
  input logic                     out_valid_i,
  input logic                     out_ready_i,
  input logic                     busy_i,
  input fp_noncomp_pkg::fp_resp_t resp_i
);

  // A stalled response holds until taken
  stable_under_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_i && !out_ready_i && !flush_i) |=> (out_valid_i && $stable(resp_i)))
    else $error("response changed while stalled");

  // Reset and flush empty the output stage
  empty_after_clear: assert property (@(posedge clk_i)
    (!rst_n_i || flush_i) |=> !out_valid_i)
    else $error("out_valid_o high after reset or flush");

  // An accepted request leaves the unit busy on the next cycle
  busy_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (in_valid_i && in_ready_i && !flush_i) |=> busy_i)
    else $error("busy_o low after an accepted request");

endmodule

bind fp_noncomp fp_noncomp_props u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .in_valid_i  (in_valid_i),
  .in_ready_i  (in_ready_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .busy_i      (busy_o),
  .resp_i      (resp_o)
);

/* verif/fp_noncomp_tb.sv */
// Testbench for the binary32 non-computational unit: vector table, back-pressure, stall and flush
`timescale 1ns/100ps

module fp_noncomp_tb;

  import fp_noncomp_pkg::*;

  // One table row with the response it should produce
  typedef struct packed {
    fp_op_e        op;
    fp_rm_e        rm;
    logic          op_mod;
    fp_word_t      a;
    fp_word_t      b;
    fp_word_t      result;
    fp_status_t    status;
    fp_classmask_e class_mask;
    logic          is_class;
  } vec_t;

  localparam int TIMEOUT_CYCLES = 200;
  // Modes of the out_ready_i driver
  localparam int BP_RANDOM = 0;
  localparam int BP_LOW    = 1;
  localparam int BP_HIGH   = 2;

  // Operand values
  localparam fp_word_t P_ONE   = 32'h3F80_0000;
  localparam fp_word_t N_ONE   = 32'hBF80_0000;
  localparam fp_word_t P_TWO   = 32'h4000_0000;
  localparam fp_word_t N_TWO   = 32'hC000_0000;
  localparam fp_word_t P_ZERO  = 32'h0000_0000;
  localparam fp_word_t N_ZERO  = 32'h8000_0000;
  localparam fp_word_t P_INF   = 32'h7F80_0000;
  localparam fp_word_t N_INF   = 32'hFF80_0000;
  localparam fp_word_t P_SUB   = 32'h0000_0001;
  localparam fp_word_t N_SUB   = 32'h8040_0000;
  localparam fp_word_t Q_NAN   = 32'h7FE0_0000;
  localparam fp_word_t NQ_NAN  = 32'hFFE0_0000;
  localparam fp_word_t S_NAN   = 32'h7F80_0001;
  // Sign 0, exponent all ones, top fraction bit only
  localparam fp_word_t CANON   = 32'h7FC0_0000;
  localparam fp_word_t TRUE_W  = 32'h0000_0001;
  localparam fp_word_t FALSE_W = 32'h0000_0000;
  localparam fp_status_t ST_OK = 5'b00000;
  localparam fp_status_t ST_NV = 5'b10000;

  logic     clk_i;
  logic     rst_n_i;
  fp_req_t  req_i;
  logic     in_valid_i;
  logic     in_ready_o;
  logic     flush_i;
  fp_resp_t resp_o;
  logic     out_valid_o;
  logic     out_ready_i;
  logic     busy_o;
  int       ready_mode;
  vec_t     vectors[$];

  fp_noncomp uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .resp_o      (resp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Output side ready, random or held
  initial begin : back_pressure
    void'($urandom(1856));
    out_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      case (ready_mode)
        BP_RANDOM: out_ready_i <= ($urandom % 3) != 0;
        BP_LOW:    out_ready_i <= 1'b0;
        default:   out_ready_i <= 1'b1;
      endcase
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic stop_on_failure();
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input fp_word_t got, input fp_word_t expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_status(input string name, input fp_status_t got,
                              input fp_status_t expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_class(input string name, input fp_classmask_e got,
                             input fp_classmask_e expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_tag(input string name, input fp_tag_t got, input fp_tag_t expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
      stop_on_failure();
    end
  endtask

  // --------------------------------------------------
  // Driver and monitor
  // --------------------------------------------------
  // Returns at the negedge before the edge that takes the row
  task automatic send_row(input int idx);
    fp_req_t req;
    int      cycles;
    req.operands[0] = vectors[idx].a;
    req.operands[1] = vectors[idx].b;
    req.op          = vectors[idx].op;
    req.rm          = vectors[idx].rm;
    req.op_mod      = vectors[idx].op_mod;
    req.tag         = fp_tag_t'(idx % 16);
    cycles          = 0;
    @(posedge clk_i);
    req_i      <= req;
    in_valid_i <= 1'b1;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout at %0t ns: row %0d was never accepted", $time, idx);
        stop_on_failure();
      end
    end while (!in_ready_o);
  endtask

  task automatic release_inputs();
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic expect_row(input int idx);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout at %0t ns: no response for row %0d", $time, idx);
        stop_on_failure();
      end
    end while (!(out_valid_o && out_ready_i));
    check_word("resp_o.result", resp_o.result, vectors[idx].result);
    check_status("resp_o.status", resp_o.status, vectors[idx].status);
    check_class("resp_o.class_mask", resp_o.class_mask, vectors[idx].class_mask);
    check_bit("resp_o.is_class", resp_o.is_class, vectors[idx].is_class);
    check_tag("resp_o.tag", resp_o.tag, fp_tag_t'(idx % 16));
  endtask

  task automatic send_all();
    for (int i = 0; i < vectors.size(); i++) begin
      send_row(i);
    end
    release_inputs();
  endtask

  task automatic expect_all();
    for (int i = 0; i < vectors.size(); i++) begin
      expect_row(i);
    end
  endtask

  // --------------------------------------------------
  // Vector table
  // --------------------------------------------------
  function automatic void add_row(input fp_op_e op, input fp_rm_e rm, input logic op_mod,
                                  input fp_word_t a, input fp_word_t b, input fp_word_t result,
                                  input fp_status_t status, input fp_classmask_e class_mask,
                                  input logic is_class);
    vec_t row;
    row = '{op, rm, op_mod, a, b, result, status, class_mask, is_class};
    vectors.push_back(row);
  endfunction

  // Class mask always follows operand a
  function automatic void load_vectors();
    // Sign injection, flags stay clear
    add_row(OP_SGNJ, RM_RNE, 1'b0, P_ONE, N_TWO, N_ONE, ST_OK, POSNORM, 1'b0);
    add_row(OP_SGNJ, RM_RTZ, 1'b0, P_ONE, N_TWO, P_ONE, ST_OK, POSNORM, 1'b0);
    add_row(OP_SGNJ, RM_RDN, 1'b0, N_ONE, N_TWO, P_ONE, ST_OK, NEGNORM, 1'b0);
    add_row(OP_SGNJ, RM_RUP, 1'b0, N_ZERO, P_ONE, N_ZERO, ST_OK, NEGZERO, 1'b0);
    add_row(OP_SGNJ, RM_RNE, 1'b0, N_ZERO, P_ONE, P_ZERO, ST_OK, NEGZERO, 1'b0);
    add_row(OP_SGNJ, RM_RTZ, 1'b0, Q_NAN, S_NAN, NQ_NAN, ST_OK, QNAN, 1'b0);
    // Min on RNE, max on RTZ
    add_row(OP_MINMAX, RM_RNE, 1'b0, P_TWO, N_ONE, N_ONE, ST_OK, POSNORM, 1'b0);
    add_row(OP_MINMAX, RM_RTZ, 1'b0, P_TWO, N_ONE, P_TWO, ST_OK, POSNORM, 1'b0);
    add_row(OP_MINMAX, RM_RNE, 1'b0, N_TWO, N_ONE, N_TWO, ST_OK, NEGNORM, 1'b0);
    add_row(OP_MINMAX, RM_RTZ, 1'b0, P_ONE, P_TWO, P_TWO, ST_OK, POSNORM, 1'b0);
    add_row(OP_MINMAX, RM_RNE, 1'b0, P_ZERO, N_ZERO, N_ZERO, ST_OK, POSZERO, 1'b0);
    add_row(OP_MINMAX, RM_RTZ, 1'b0, N_ZERO, P_ZERO, P_ZERO, ST_OK, NEGZERO, 1'b0);
    add_row(OP_MINMAX, RM_RNE, 1'b0, Q_NAN, P_ONE, P_ONE, ST_OK, QNAN, 1'b0);
    add_row(OP_MINMAX, RM_RTZ, 1'b0, N_ONE, Q_NAN, N_ONE, ST_OK, NEGNORM, 1'b0);
    add_row(OP_MINMAX, RM_RNE, 1'b0, Q_NAN, NQ_NAN, CANON, ST_OK, QNAN, 1'b0);
    add_row(OP_MINMAX, RM_RTZ, 1'b0, S_NAN, P_TWO, P_TWO, ST_NV, SNAN, 1'b0);
    add_row(OP_MINMAX, RM_RNE, 1'b0, Q_NAN, S_NAN, CANON, ST_NV, QNAN, 1'b0);
    // LE on RNE, LT on RTZ, EQ on RDN
    add_row(OP_CMP, RM_RNE, 1'b0, P_ZERO, N_ZERO, TRUE_W, ST_OK, POSZERO, 1'b0);
    add_row(OP_CMP, RM_RTZ, 1'b0, P_ZERO, N_ZERO, FALSE_W, ST_OK, POSZERO, 1'b0);
    add_row(OP_CMP, RM_RDN, 1'b0, N_ZERO, P_ZERO, TRUE_W, ST_OK, NEGZERO, 1'b0);
    add_row(OP_CMP, RM_RNE, 1'b1, P_ZERO, N_ZERO, FALSE_W, ST_OK, POSZERO, 1'b0);
    add_row(OP_CMP, RM_RTZ, 1'b1, P_ZERO, N_ZERO, TRUE_W, ST_OK, POSZERO, 1'b0);
    add_row(OP_CMP, RM_RDN, 1'b1, P_ONE, P_TWO, TRUE_W, ST_OK, POSNORM, 1'b0);
    add_row(OP_CMP, RM_RTZ, 1'b0, N_TWO, P_ONE, TRUE_W, ST_OK, NEGNORM, 1'b0);
    add_row(OP_CMP, RM_RNE, 1'b0, P_TWO, P_ONE, FALSE_W, ST_OK, POSNORM, 1'b0);
    // Quiet NaN is invalid for LE and LT only
    add_row(OP_CMP, RM_RNE, 1'b0, Q_NAN, P_ONE, FALSE_W, ST_NV, QNAN, 1'b0);
    add_row(OP_CMP, RM_RTZ, 1'b1, P_ONE, Q_NAN, TRUE_W, ST_NV, POSNORM, 1'b0);
    add_row(OP_CMP, RM_RDN, 1'b0, Q_NAN, Q_NAN, FALSE_W, ST_OK, QNAN, 1'b0);
    add_row(OP_CMP, RM_RDN, 1'b1, Q_NAN, P_ONE, TRUE_W, ST_OK, QNAN, 1'b0);
    // Signalling NaN stays false even with the modifier
    add_row(OP_CMP, RM_RDN, 1'b1, S_NAN, P_ONE, FALSE_W, ST_NV, SNAN, 1'b0);
    add_row(OP_CMP, RM_RNE, 1'b1, P_ONE, S_NAN, FALSE_W, ST_NV, POSNORM, 1'b0);
    add_row(OP_CMP, RM_RTZ, 1'b0, S_NAN, S_NAN, FALSE_W, ST_NV, SNAN, 1'b0);
    // All ten classes
    add_row(OP_CLASSIFY, RM_RNE, 1'b0, N_INF, P_ONE, FALSE_W, ST_OK, NEGINF, 1'b1);
    add_row(OP_CLASSIFY, RM_RNE, 1'b0, N_ONE, P_ONE, FALSE_W, ST_OK, NEGNORM, 1'b1);
    add_row(OP_CLASSIFY, RM_RNE, 1'b0, N_SUB, P_ONE, FALSE_W, ST_OK, NEGSUBNORM, 1'b1);
    add_row(OP_CLASSIFY, RM_RNE, 1'b0, N_ZERO, P_ONE, FALSE_W, ST_OK, NEGZERO, 1'b1);
    add_row(OP_CLASSIFY, RM_RNE, 1'b0, P_ZERO, P_ONE, FALSE_W, ST_OK, POSZERO, 1'b1);
    add_row(OP_CLASSIFY, RM_RNE, 1'b0, P_SUB, P_ONE, FALSE_W, ST_OK, POSSUBNORM, 1'b1);
    add_row(OP_CLASSIFY, RM_RNE, 1'b0, P_ONE, P_ONE, FALSE_W, ST_OK, POSNORM, 1'b1);
    add_row(OP_CLASSIFY, RM_RNE, 1'b0, P_INF, P_ONE, FALSE_W, ST_OK, POSINF, 1'b1);
    add_row(OP_CLASSIFY, RM_RNE, 1'b0, S_NAN, P_ONE, FALSE_W, ST_OK, SNAN, 1'b1);
    add_row(OP_CLASSIFY, RM_RNE, 1'b0, Q_NAN, P_ONE, FALSE_W, ST_OK, QNAN, 1'b1);
  endfunction

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main_sequence
    ready_mode = BP_HIGH;
    rst_n_i    = 1'b0;
    in_valid_i = 1'b0;
    flush_i    = 1'b0;
    req_i      = '0;
    load_vectors();
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("in_ready_o", in_ready_o, 1'b1);

    // Whole table under random back-pressure, in order
    ready_mode = BP_RANDOM;
    fork
      send_all();
      expect_all();
    join
    @(negedge clk_i);
    check_bit("busy_o", busy_o, 1'b0);

    // Output held, two items fill both stages
    ready_mode = BP_LOW;
    send_row(0);
    send_row(1);
    release_inputs();
    @(negedge clk_i);
    check_bit("in_ready_o", in_ready_o, 1'b0);
    check_bit("out_valid_o", out_valid_o, 1'b1);
    ready_mode = BP_HIGH;
    expect_row(0);
    expect_row(1);

    // Flush two items in flight
    ready_mode = BP_LOW;
    send_row(2);
    send_row(3);
    release_inputs();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    ready_mode = BP_HIGH;
    send_row(4);
    release_inputs();
    expect_row(4);

    $display("Simulation PASSED");
    $finish;
  end

endmodule
